//--- source/len5_defines.svh
// ==================================================
// Global sizes for the branch resolution stage
// Operand width, immediate width, refill penalty
// ==================================================

`ifndef LEN5_DEFINES_SVH
`define LEN5_DEFINES_SVH

// Operand and address width, one RISC-V word
`define LEN5_XLEN 32

// Branch immediate width, bit 0 of the offset is implicit
`define LEN5_B_IMM 12

// Cycles spent in the flush state after a misprediction
`define LEN5_FLUSH_CYCLES 3

`endif

//--- source/len5_pkg.sv
// ==================================================
// Shared types of the branch resolution stage
// Branch condition codes and control unit states
// ==================================================

`default_nettype none

package len5_pkg;

  // Branch condition, encoded as the RISC-V funct3 field
  // Codes 3'b010 and 3'b011 are unused and never taken
  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_type_t;

  // Control unit states
  typedef enum logic [1:0] {
    CU_IDLE     = 2'd0,
    CU_RES_OK   = 2'd1,
    CU_RES_MISS = 2'd2,
    CU_FLUSH    = 2'd3
  } cu_state_t;

endpackage

`default_nettype wire

//--- source/branch_cmp.sv
// ==================================================
// Branch comparator
// Decides the branch direction from the two source
// operands and the branch condition code
// ==================================================

`default_nettype none

`include "len5_defines.svh"

module branch_cmp (
  input  logic [`LEN5_XLEN-1:0] rs1_i,
  input  logic [`LEN5_XLEN-1:0] rs2_i,
  input  len5_pkg::branch_type_t type_i,
  output logic                  taken_o
);

  import len5_pkg::*;

  // Both flavours of less-than, shared by the six conditions
  logic lt_signed;
  logic lt_unsigned;
  logic equal;

  assign equal       = (rs1_i == rs2_i);
  assign lt_signed   = ($signed(rs1_i) < $signed(rs2_i));
  assign lt_unsigned = (rs1_i < rs2_i);

  // Condition select
  always_comb begin
    case (type_i)
      beq:     taken_o = equal;
      bne:     taken_o = !equal;
      blt:     taken_o = lt_signed;
      bge:     taken_o = !lt_signed;
      bltu:    taken_o = lt_unsigned;
      bgeu:    taken_o = !lt_unsigned;
      // Unused codes
      default: taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/branch_target.sv
// ==================================================
// Branch target path
// Computes the taken target from the branch address,
// checks it against the prediction and holds the
// resolved addresses for the result cycle
// ==================================================

`default_nettype none

`include "len5_defines.svh"

module branch_target (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   accept_i,
  input  logic                   taken_i,
  input  logic                   pred_taken_i,
  input  logic [`LEN5_XLEN-1:0]  pred_pc_i,
  input  logic [`LEN5_XLEN-1:0]  pred_target_i,
  input  logic [`LEN5_B_IMM-1:0] imm_i,
  output logic                   mispredict_o,
  output logic [`LEN5_XLEN-1:0]  res_pc_o,
  output logic [`LEN5_XLEN-1:0]  res_target_o
);

  logic [`LEN5_XLEN-1:0] offset;
  logic [`LEN5_XLEN-1:0] target;
  logic                  wrong_dir;
  logic                  wrong_target;

  // Offset is the immediate sign extended, with a zero LSB appended
  assign offset = {{(`LEN5_XLEN-`LEN5_B_IMM-1){imm_i[`LEN5_B_IMM-1]}}, imm_i, 1'b0};
  assign target = pred_pc_i + offset;

  // Direction check
  assign wrong_dir = (pred_taken_i != taken_i);
  // Target only matters when both sides agree on taken
  assign wrong_target = taken_i && pred_taken_i && (pred_target_i != target);

  assign mispredict_o = wrong_dir || wrong_target;

  // Resolved addresses, loaded on accept and held otherwise
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_pc_o     <= '0;
      res_target_o <= '0;
    end else if (accept_i) begin
      res_pc_o     <= pred_pc_i;
      res_target_o <= target;
    end
  end

endmodule

`default_nettype wire

//--- source/branch_unit_cu.sv
// ==================================================
// Branch unit control
// Handles the input handshake, the one-cycle result
// strobe and the stall while the core refills after
// a misprediction
// ==================================================

`default_nettype none

module branch_unit_cu (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic ops_valid_i,
  input  logic taken_i,
  input  logic mispredict_i,
  input  logic timer_done_i,
  output logic ops_ready_o,
  output logic accept_o,
  output logic res_valid_o,
  output logic res_taken_o,
  output logic res_mispredict_o,
  output logic timer_start_o
);

  import len5_pkg::*;

  cu_state_t state_q;
  cu_state_t state_d;

  // Result flags captured at accept
  logic taken_q;
  logic miss_q;

  // Ready in the idle state and while a good result is out
  assign ops_ready_o = (state_q == CU_IDLE) || (state_q == CU_RES_OK);
  assign accept_o    = ops_valid_i && ops_ready_o;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CU_IDLE, CU_RES_OK: begin
        if (accept_o) begin
          state_d = mispredict_i ? CU_RES_MISS : CU_RES_OK;
        end else begin
          state_d = CU_IDLE;
        end
      end
      // Result cycle of a miss, timer is kicked off here
      CU_RES_MISS: state_d = CU_FLUSH;
      // Hold until the refill penalty has elapsed
      CU_FLUSH: begin
        if (timer_done_i) begin
          state_d = CU_IDLE;
        end
      end
      default: state_d = CU_IDLE;
    endcase
  end

  // State and flag registers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CU_IDLE;
      taken_q <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Flags only live during the result cycle
      taken_q <= accept_o && taken_i;
      miss_q  <= accept_o && mispredict_i;
    end
  end

  // Result strobe in both result states
  assign res_valid_o      = (state_q == CU_RES_OK) || (state_q == CU_RES_MISS);
  assign res_taken_o      = taken_q;
  assign res_mispredict_o = miss_q;

  // One-cycle start pulse for the refill timer
  assign timer_start_o = (state_q == CU_RES_MISS);

endmodule

`default_nettype wire

//--- source/flush_timer.sv
// ==================================================
// Refill penalty timer
// Counts the flush cycles after a misprediction and
// pulses done in the last one
// ==================================================

`default_nettype none

`include "len5_defines.svh"

module flush_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  output logic busy_o,
  output logic done_o
);

  // Wide enough to hold the penalty itself
  localparam int unsigned CntW = $clog2(`LEN5_FLUSH_CYCLES + 1);

  logic [CntW-1:0] count_q;

  // Start reloads, otherwise count down to zero and stay there
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= CntW'(`LEN5_FLUSH_CYCLES);
    end else if (count_q != '0) begin
      count_q <= count_q - CntW'(1);
    end
  end

  assign busy_o = (count_q != '0);

  // Last counting cycle
  assign done_o = (count_q == CntW'(1));

endmodule

`default_nettype wire

//--- source/branch_unit.sv
// ==================================================
// Branch resolution stage
// Resolves conditional branches, computes targets,
// flags mispredictions and stalls for the refill
// ==================================================

`default_nettype none

`include "len5_defines.svh"

module branch_unit (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Operation input
  input  logic                   ops_valid_i,
  output logic                   ops_ready_o,
  input  logic [`LEN5_XLEN-1:0]  rs1_i,
  input  logic [`LEN5_XLEN-1:0]  rs2_i,
  input  logic [`LEN5_B_IMM-1:0] imm_i,
  input  len5_pkg::branch_type_t type_i,
  input  logic [`LEN5_XLEN-1:0]  pred_pc_i,
  input  logic [`LEN5_XLEN-1:0]  pred_target_i,
  input  logic                   pred_taken_i,
  // Resolved result, valid for one cycle
  output logic                   res_valid_o,
  output logic [`LEN5_XLEN-1:0]  res_pc_o,
  output logic [`LEN5_XLEN-1:0]  res_target_o,
  output logic                   res_taken_o,
  output logic                   res_mispredict_o
);

  logic taken;
  logic mispredict;
  logic accept;
  logic timer_start;
  logic timer_done;

  // Direction
  branch_cmp branch_cmp_inst (
    .rs1_i   (rs1_i),
    .rs2_i   (rs2_i),
    .type_i  (type_i),
    .taken_o (taken)
  );

  // Target, miss check and address registers
  branch_target branch_target_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .accept_i      (accept),
    .taken_i       (taken),
    .pred_taken_i  (pred_taken_i),
    .pred_pc_i     (pred_pc_i),
    .pred_target_i (pred_target_i),
    .imm_i         (imm_i),
    .mispredict_o  (mispredict),
    .res_pc_o      (res_pc_o),
    .res_target_o  (res_target_o)
  );

  // Handshake and result strobe
  branch_unit_cu branch_unit_cu_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ops_valid_i      (ops_valid_i),
    .taken_i          (taken),
    .mispredict_i     (mispredict),
    .timer_done_i     (timer_done),
    .ops_ready_o      (ops_ready_o),
    .accept_o         (accept),
    .res_valid_o      (res_valid_o),
    .res_taken_o      (res_taken_o),
    .res_mispredict_o (res_mispredict_o),
    .timer_start_o    (timer_start)
  );

  // Refill penalty
  flush_timer flush_timer_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (timer_start),
    .busy_o  (),
    .done_o  (timer_done)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// ==================================================
// Testbench clock generator
// Free-running clock with a 40 ns period
// ==================================================

`default_nettype none

module tb_clock (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // Half of the 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- testbench/tb_branch_unit.sv
// ==================================================
// Testbench for the branch resolution stage
// Directed tests against a reference model of the
// RISC-V branch rules, with a cycle-count timeout
// ==================================================

`default_nettype none

`include "len5_defines.svh"

module tb_branch_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import len5_pkg::*;

  // Well above the couple of hundred cycles that all tests take
  localparam int timeout_cycles = 2000;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   ops_valid_i;
  logic                   ops_ready_o;
  logic [`LEN5_XLEN-1:0]  rs1_i;
  logic [`LEN5_XLEN-1:0]  rs2_i;
  logic [`LEN5_B_IMM-1:0] imm_i;
  branch_type_t           type_i;
  logic [`LEN5_XLEN-1:0]  pred_pc_i;
  logic [`LEN5_XLEN-1:0]  pred_target_i;
  logic                   pred_taken_i;
  logic                   res_valid_o;
  logic [`LEN5_XLEN-1:0]  res_pc_o;
  logic [`LEN5_XLEN-1:0]  res_target_o;
  logic                   res_taken_o;
  logic                   res_mispredict_o;

  // Expected result of the operation last driven
  logic [`LEN5_XLEN-1:0]  exp_pc;
  logic [`LEN5_XLEN-1:0]  exp_target;
  logic                   exp_taken;
  logic                   exp_miss;

  int num_checks;
  int num_errors;
  int test_errors;
  int cycle_count;

  tb_clock tb_clock_inst (.clk_o(clk_i));

  // Port names match the local signals
  branch_unit branch_unit_inst (.*);

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // Direction from the RISC-V conditions
  // Unused codes are never taken
  function automatic logic ref_taken(input logic [`LEN5_XLEN-1:0] a, b, input branch_type_t t);
    case (t)
      beq:     return a == b;
      bne:     return a != b;
      blt:     return $signed(a) < $signed(b);
      bge:     return $signed(a) >= $signed(b);
      bltu:    return a < b;
      bgeu:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Branch address plus the sign-extended immediate times two
  function automatic logic [`LEN5_XLEN-1:0] ref_target(input logic [`LEN5_XLEN-1:0] pc,
                                                       input logic [`LEN5_B_IMM-1:0] imm);
    logic [`LEN5_XLEN-1:0] sext;
    sext = {{(`LEN5_XLEN-`LEN5_B_IMM){imm[`LEN5_B_IMM-1]}}, imm};
    return pc + (sext << 1);
  endfunction

  // Wrong direction, or both taken towards different targets
  function automatic logic ref_miss(input logic taken, pred_taken,
                                    input logic [`LEN5_XLEN-1:0] target, pred_target);
    if (taken != pred_taken) begin
      return 1'b1;
    end
    return taken && (target != pred_target);
  endfunction

  task automatic check_addr(input string what, input logic [`LEN5_XLEN-1:0] got, exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      test_errors++;
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      test_errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, exp);
    num_checks++;
    if (got != exp) begin
      num_errors++;
      test_errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // Next rising edge, then the drive delay
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_ready();
    while (ops_ready_o !== 1'b1) begin
      step();
    end
  endtask

  // Present one operation once ready and work out its result
  task automatic drive_op(input logic [`LEN5_XLEN-1:0] a, b, input logic [`LEN5_B_IMM-1:0] imm,
                          input branch_type_t t, input logic [`LEN5_XLEN-1:0] pc, ptarget,
                          input logic ptaken);
    wait_ready();
    ops_valid_i   = 1'b1;
    rs1_i         = a;
    rs2_i         = b;
    imm_i         = imm;
    type_i        = t;
    pred_pc_i     = pc;
    pred_target_i = ptarget;
    pred_taken_i  = ptaken;
    exp_pc        = pc;
    exp_target    = ref_target(pc, imm);
    exp_taken     = ref_taken(a, b, t);
    exp_miss      = ref_miss(exp_taken, ptaken, exp_target, ptarget);
  endtask

  // Prediction that matches the resolved branch
  task automatic drive_good(input logic [`LEN5_XLEN-1:0] a, b, input logic [`LEN5_B_IMM-1:0] imm,
                            input branch_type_t t, input logic [`LEN5_XLEN-1:0] pc);
    drive_op(a, b, imm, t, pc, ref_target(pc, imm), ref_taken(a, b, t));
  endtask

  task automatic check_result();
    check_flag("res_valid_o", res_valid_o, 1'b1);
    check_addr("res_pc_o", res_pc_o, exp_pc);
    check_addr("res_target_o", res_target_o, exp_target);
    check_flag("res_taken_o", res_taken_o, exp_taken);
    check_flag("res_mispredict_o", res_mispredict_o, exp_miss);
    check_flag("ops_ready_o in result cycle", ops_ready_o, !exp_miss);
  endtask

  // Accept edge, drop valid, then look at the result
  task automatic complete_op();
    step();
    ops_valid_i = 1'b0;
    check_result();
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, test_errors);
    test_errors = 0;
  endtask

  task automatic test_reset_state();
    check_flag("ops_ready_o after reset", ops_ready_o, 1'b1);
    check_flag("res_valid_o after reset", res_valid_o, 1'b0);
    check_flag("res_taken_o after reset", res_taken_o, 1'b0);
    check_flag("res_mispredict_o after reset", res_mispredict_o, 1'b0);
    check_addr("res_pc_o after reset", res_pc_o, '0);
    check_addr("res_target_o after reset", res_target_o, '0);
    end_test("reset_state");
  endtask

  task automatic test_branch_types();
    branch_type_t          types [6];
    logic [`LEN5_XLEN-1:0] lhs [5];
    logic [`LEN5_XLEN-1:0] rhs [5];
    types = '{beq, bne, blt, bge, bltu, bgeu};
    // Equal, smaller, larger, negative vs positive, positive vs negative
    lhs = '{32'd5, 32'd3, 32'd7, 32'hffff_fff0, 32'd1};
    rhs = '{32'd5, 32'd7, 32'd3, 32'd1, 32'h8000_0000};
    for (int t = 0; t < 6; t++) begin
      for (int k = 0; k < 5; k++) begin
        drive_good(lhs[k], rhs[k], 12'(t * 40 + k), types[t], 32'h0000_2000 + 32'(t * 64 + k * 4));
        complete_op();
      end
    end
    end_test("branch_types");
  endtask

  task automatic test_direction_miss();
    int low_cycles;
    // Predicted taken but falls through, then the reverse
    for (int k = 0; k < 2; k++) begin
      drive_op(32'd9, 32'd9, 12'h010, (k == 0) ? bne : beq, 32'h0000_3000, 32'h0000_3020, k == 0);
      complete_op();
      low_cycles = 1;
      step();
      check_flag("res_valid_o after result", res_valid_o, 1'b0);
      while (ops_ready_o !== 1'b1) begin
        low_cycles++;
        step();
      end
      check_count("cycles with ops_ready_o low", low_cycles, 1 + `LEN5_FLUSH_CYCLES);
    end
    end_test("direction_miss");
  endtask

  task automatic test_target_miss();
    // Taken as predicted but the prediction used a positive offset
    drive_op(32'd4, 32'd4, 12'hff0, beq, 32'h0000_1000, 32'h0000_2fe0, 1'b1);
    complete_op();
    check_addr("target with negative offset", res_target_o, 32'h0000_0fe0);
    wait_ready();
    end_test("target_miss");
  endtask

  task automatic test_back_to_back();
    // Each cycle checks the previous result and issues the next
    for (int k = 0; k < 6; k++) begin
      drive_good(32'(k), 32'd2, 12'(8 * k), (k % 2 == 1) ? blt : bgeu, 32'h0000_4000 + 32'(4 * k));
      step();
      check_result();
    end
    ops_valid_i = 1'b0;
    step();
    check_flag("res_valid_o after last result", res_valid_o, 1'b0);
    end_test("back_to_back");
  endtask

  task automatic test_random_ops();
    logic [31:0]            r;
    logic [`LEN5_XLEN-1:0]  a;
    logic [`LEN5_XLEN-1:0]  b;
    logic [`LEN5_XLEN-1:0]  pc;
    logic [`LEN5_XLEN-1:0]  tgt;
    logic [`LEN5_B_IMM-1:0] imm;
    for (int n = 0; n < 20; n++) begin
      r  = $urandom();
      a  = $urandom();
      // Equal operands one time in four
      b  = (r[1:0] == 2'd0) ? a : $urandom();
      imm = r[13:2];
      pc  = $urandom() & 32'hffff_fffc;
      // Correct target half of the time
      tgt = r[18] ? ref_target(pc, imm) : $urandom();
      // Type drawn from all eight codes
      drive_op(a, b, imm, branch_type_t'(r[16:14]), pc, tgt, r[17]);
      complete_op();
    end
    wait_ready();
    end_test("random_ops");
  endtask

  initial begin
    void'($urandom(64079));
    ops_valid_i   = 1'b0;
    rs1_i         = '0;
    rs2_i         = '0;
    imm_i         = '0;
    type_i        = beq;
    pred_pc_i     = '0;
    pred_target_i = '0;
    pred_taken_i  = 1'b0;
    rst_n_i       = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    test_reset_state();
    test_branch_types();
    test_direction_miss();
    test_target_miss();
    test_back_to_back();
    test_random_ops();
    $display("Tests done with %0d checks and %0d errors", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/len5_pkg.sv
source/branch_cmp.sv
source/branch_target.sv
source/branch_unit_cu.sv
source/flush_timer.sv
source/branch_unit.sv
testbench/tb_clock.sv
testbench/tb_branch_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f tb.f \
  --top-module tb_branch_unit -o tb_branch_unit

./obj_dir/tb_branch_unit > sim.log
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
